// File: common/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0]    word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    // Kept major opcodes
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcode_t;

    // R-type function field
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp_t;

    // Same word seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            regAddr_t   rs;
            regAddr_t   rt;
            regAddr_t   rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            regAddr_t    rs;
            regAddr_t    rt;
            logic [15:0] imm;
        } i;
    } instr_t;

    typedef enum logic [1:0] {
        fwdReg,
        fwdMem,
        fwdWb
    } fwdSel_t;

endpackage

`default_nettype wire

// File: hw/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit import mipsPkg::*; (
    input  wire           idExMemRead,
    input  wire regAddr_t idExRd,
    input  wire regAddr_t ifIdRs,
    input  wire regAddr_t ifIdRt,
    input  wire           branchTaken,
    output logic          stall,
    output logic          flush
);

    logic loadUse;

    // Load result not ready for the instruction behind it
    assign loadUse = idExMemRead && (idExRd != '0)
                     && ((idExRd == ifIdRs) || (idExRd == ifIdRt));

    // The squashed instructions never need the stall
    assign flush = branchTaken;
    assign stall = loadUse && !branchTaken;

endmodule

`default_nettype wire

// File: hw/fetch/fetchStage.sv
`timescale 1ns/1ns
`default_nettype none

module fetchStage import mipsPkg::*; #(
    parameter word_t ResetPc = '0
) (
    input  wire         clk,
    input  wire         arstN,
    input  wire         stall,
    input  wire         flush,
    input  wire         branchTaken,
    input  wire word_t  branchTarget,
    output word_t       instrAddr,
    input  wire instr_t instr,
    output instr_t      ifIdInstr,
    output word_t       ifIdPcPlus4
);

    word_t pc;
    word_t pcPlus4;

    assign instrAddr = pc;
    assign pcPlus4   = pc + word_t'(4);

    // Branch target beats the stall hold
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= ResetPc;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall) begin
            pc <= pcPlus4;
        end
    end

    // IF/ID instruction with the all-zero word as bubble
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ifIdInstr <= '0;
        end else if (flush) begin
            ifIdInstr <= '0;
        end else if (!stall) begin
            ifIdInstr <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifIdPcPlus4 <= pcPlus4;
        end
    end

endmodule

`default_nettype wire

// File: hw/decode/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile import mipsPkg::*; (
    input  wire           clk,
    input  wire           arstN,
    input  wire regAddr_t rsAddr,
    input  wire regAddr_t rtAddr,
    output word_t         rsData,
    output word_t         rtData,
    input  wire           wrEn,
    input  wire regAddr_t wrAddr,
    input  wire word_t    wrData
);

    word_t regs [2**regAddrWidth];
    logic  wrLive;

    // Register zero is never written
    assign wrLive = wrEn && (wrAddr != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int k = 0; k < 2**regAddrWidth; k++) begin
                regs[k] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Same-cycle write shows through to the reads
    assign rsData = (wrLive && (wrAddr == rsAddr)) ? wrData : regs[rsAddr];
    assign rtData = (wrLive && (wrAddr == rtAddr)) ? wrData : regs[rtAddr];

endmodule

`default_nettype wire

// File: hw/decode/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage import mipsPkg::*; (
    input  wire           clk,
    input  wire           arstN,
    input  wire           stall,
    input  wire           flush,
    input  wire instr_t   ifIdInstr,
    input  wire word_t    ifIdPcPlus4,
    input  wire           wbEn,
    input  wire regAddr_t wbRegIn,
    input  wire word_t    wbDataIn,
    output aluOp_t        exAluOp,
    output logic          exAluSrcImm,
    output logic          exBranch,
    output logic          exMemRead,
    output logic          exMemWrite,
    output logic          exMemToReg,
    output logic          exRegWrite,
    output regAddr_t      exRs,
    output regAddr_t      exRt,
    output regAddr_t      exRd,
    output word_t         exRsData,
    output word_t         exRtData,
    output word_t         exImm,
    output word_t         exPcPlus4
);

    aluOp_t   aluOp;
    logic     aluSrcImm;
    logic     branch;
    logic     memRead;
    logic     memWrite;
    logic     memToReg;
    logic     regWrite;
    regAddr_t destReg;
    word_t    rsData;
    word_t    rtData;
    word_t    imm;

    regFile regFile0 (
        .clk(clk),
        .arstN(arstN),
        .rsAddr(ifIdInstr.r.rs),
        .rtAddr(ifIdInstr.r.rt),
        .rsData(rsData),
        .rtData(rtData),
        .wrEn(wbEn),
        .wrAddr(wbRegIn),
        .wrData(wbDataIn)
    );

    assign imm = {{(dataWidth-16){ifIdInstr.i.imm[15]}}, ifIdInstr.i.imm};

    // Unknown encodings fall through with every control bit low
    always_comb begin
        aluOp     = aluAdd;
        aluSrcImm = 1'b0;
        branch    = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        regWrite  = 1'b0;
        destReg   = ifIdInstr.i.rt;
        case (ifIdInstr.r.opcode)
            opRType: begin
                destReg  = ifIdInstr.r.rd;
                regWrite = 1'b1;
                case (ifIdInstr.r.funct)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: regWrite = 1'b0;
                endcase
            end
            opAddi: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            opLw: begin
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                memToReg  = 1'b1;
                regWrite  = 1'b1;
            end
            opSw: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            opBeq: begin
                aluOp  = aluSub;
                branch = 1'b1;
            end
            default: ;
        endcase
    end

    // ID/EX control bits cleared into a bubble on stall or flush
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            {exBranch, exMemRead, exMemWrite, exMemToReg, exRegWrite} <= '0;
        end else if (stall || flush) begin
            {exBranch, exMemRead, exMemWrite, exMemToReg, exRegWrite} <= '0;
        end else begin
            {exBranch, exMemRead, exMemWrite, exMemToReg, exRegWrite} <=
                {branch, memRead, memWrite, memToReg, regWrite};
        end
    end

    always_ff @(posedge clk) begin
        exAluOp     <= aluOp;
        exAluSrcImm <= aluSrcImm;
        exRs        <= ifIdInstr.r.rs;
        exRt        <= ifIdInstr.r.rt;
        exRd        <= destReg;
        exRsData    <= rsData;
        exRtData    <= rtData;
        exImm       <= imm;
        exPcPlus4   <= ifIdPcPlus4;
    end

endmodule

`default_nettype wire

// File: hw/execute/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage import mipsPkg::*; (
    input  wire           clk,
    input  wire           arstN,
    input  wire aluOp_t   exAluOp,
    input  wire           exAluSrcImm,
    input  wire           exBranch,
    input  wire           exMemRead,
    input  wire           exMemWrite,
    input  wire           exMemToReg,
    input  wire           exRegWrite,
    input  wire regAddr_t exRs,
    input  wire regAddr_t exRt,
    input  wire regAddr_t exRd,
    input  wire word_t    exRsData,
    input  wire word_t    exRtData,
    input  wire word_t    exImm,
    input  wire word_t    exPcPlus4,
    input  wire           wbEn,
    input  wire regAddr_t wbRegIn,
    input  wire word_t    wbDataIn,
    output logic          branchTaken,
    output word_t         branchTarget,
    output word_t         memAluResult,
    output word_t         memStoreData,
    output regAddr_t      memRd,
    output logic          memRegWrite,
    output logic          memMemRead,
    output logic          memMemWrite,
    output logic          memMemToReg
);

    fwdSel_t fwdA;
    fwdSel_t fwdB;
    word_t   opA;
    word_t   opB;
    word_t   aluB;
    word_t   aluResult;

    // Younger EX/MEM result takes priority over write-back
    function automatic fwdSel_t pickSource(regAddr_t src, logic memWr, regAddr_t memDst,
                                           logic wbWr, regAddr_t wbDst);
        if (memWr && (memDst != '0) && (memDst == src)) begin
            return fwdMem;
        end
        if (wbWr && (wbDst != '0) && (wbDst == src)) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign fwdA = pickSource(exRs, memRegWrite, memRd, wbEn, wbRegIn);
    assign fwdB = pickSource(exRt, memRegWrite, memRd, wbEn, wbRegIn);

    assign opA = (fwdA == fwdMem) ? memAluResult :
                 (fwdA == fwdWb)  ? wbDataIn     : exRsData;
    assign opB = (fwdB == fwdMem) ? memAluResult :
                 (fwdB == fwdWb)  ? wbDataIn     : exRtData;

    assign aluB = exAluSrcImm ? exImm : opB;

    always_comb begin
        case (exAluOp)
            aluSub:  aluResult = opA - aluB;
            aluAnd:  aluResult = opA & aluB;
            aluOr:   aluResult = opA | aluB;
            aluSlt:  aluResult = word_t'($signed(opA) < $signed(aluB));
            default: aluResult = opA + aluB;
        endcase
    end

    // beq resolves here on the forwarded operands
    assign branchTarget = exPcPlus4 + {exImm[dataWidth-3:0], 2'b00};
    assign branchTaken  = exBranch && (opA == opB);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            {memRegWrite, memMemRead, memMemWrite, memMemToReg} <= '0;
        end else begin
            {memRegWrite, memMemRead, memMemWrite, memMemToReg} <=
                {exRegWrite, exMemRead, exMemWrite, exMemToReg};
        end
    end

    always_ff @(posedge clk) begin
        memAluResult <= aluResult;
        memStoreData <= opB;
        memRd        <= exRd;
    end

endmodule

`default_nettype wire

// File: hw/memory/memStage.sv
`timescale 1ns/1ns
`default_nettype none

module memStage import mipsPkg::*; #(
    parameter int DataWords = 256
) (
    input  wire           clk,
    input  wire           arstN,
    input  wire word_t    memAluResult,
    input  wire word_t    memStoreData,
    input  wire regAddr_t memRd,
    input  wire           memRegWrite,
    input  wire           memMemRead,
    input  wire           memMemWrite,
    input  wire           memMemToReg,
    output logic          wbEn,
    output regAddr_t      wbReg,
    output word_t         wbData
);

    localparam int AddrBits = $clog2(DataWords);

    word_t               dataMem [DataWords];
    logic [AddrBits-1:0] wordIdx;
    word_t               loadData;

    // Byte address in, word index out
    assign wordIdx = memAluResult[AddrBits+1:2];

    always_ff @(posedge clk) begin
        if (memMemWrite) begin
            dataMem[wordIdx] <= memStoreData;
        end
    end

    assign loadData = memMemRead ? dataMem[wordIdx] : '0;

    // MEM/WB valid only for a real destination
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbEn <= 1'b0;
        end else begin
            wbEn <= memRegWrite && (memRd != '0);
        end
    end

    always_ff @(posedge clk) begin
        wbReg  <= memRd;
        wbData <= memMemToReg ? loadData : memAluResult;
    end

endmodule

`default_nettype wire

// File: hw/mipsCore.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore import mipsPkg::*; #(
    parameter word_t ResetPc   = '0,
    parameter int    DataWords = 256
) (
    input  wire         clk,
    input  wire         arstN,
    output word_t       instrAddr,
    input  wire instr_t instr,
    output logic        wbValid,
    output regAddr_t    wbReg,
    output word_t       wbData
);

    logic     stall;
    logic     flush;
    logic     branchTaken;
    word_t    branchTarget;
    instr_t   ifIdInstr;
    word_t    ifIdPcPlus4;

    aluOp_t   exAluOp;
    logic     exAluSrcImm;
    logic     exBranch;
    logic     exMemRead;
    logic     exMemWrite;
    logic     exMemToReg;
    logic     exRegWrite;
    regAddr_t exRs;
    regAddr_t exRt;
    regAddr_t exRd;
    word_t    exRsData;
    word_t    exRtData;
    word_t    exImm;
    word_t    exPcPlus4;

    word_t    memAluResult;
    word_t    memStoreData;
    regAddr_t memRd;
    logic     memRegWrite;
    logic     memMemRead;
    logic     memMemWrite;
    logic     memMemToReg;

    fetchStage #(
        .ResetPc(ResetPc)
    ) fetch0 (
        .clk(clk),
        .arstN(arstN),
        .stall(stall),
        .flush(flush),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .instrAddr(instrAddr),
        .instr(instr),
        .ifIdInstr(ifIdInstr),
        .ifIdPcPlus4(ifIdPcPlus4)
    );

    hazardUnit hazard0 (
        .idExMemRead(exMemRead),
        .idExRd(exRd),
        .ifIdRs(ifIdInstr.r.rs),
        .ifIdRt(ifIdInstr.r.rt),
        .branchTaken(branchTaken),
        .stall(stall),
        .flush(flush)
    );

    decodeStage decode0 (
        .clk(clk),
        .arstN(arstN),
        .stall(stall),
        .flush(flush),
        .ifIdInstr(ifIdInstr),
        .ifIdPcPlus4(ifIdPcPlus4),
        .wbEn(wbValid),
        .wbRegIn(wbReg),
        .wbDataIn(wbData),
        .exAluOp(exAluOp),
        .exAluSrcImm(exAluSrcImm),
        .exBranch(exBranch),
        .exMemRead(exMemRead),
        .exMemWrite(exMemWrite),
        .exMemToReg(exMemToReg),
        .exRegWrite(exRegWrite),
        .exRs(exRs),
        .exRt(exRt),
        .exRd(exRd),
        .exRsData(exRsData),
        .exRtData(exRtData),
        .exImm(exImm),
        .exPcPlus4(exPcPlus4)
    );

    executeStage execute0 (
        .clk(clk),
        .arstN(arstN),
        .exAluOp(exAluOp),
        .exAluSrcImm(exAluSrcImm),
        .exBranch(exBranch),
        .exMemRead(exMemRead),
        .exMemWrite(exMemWrite),
        .exMemToReg(exMemToReg),
        .exRegWrite(exRegWrite),
        .exRs(exRs),
        .exRt(exRt),
        .exRd(exRd),
        .exRsData(exRsData),
        .exRtData(exRtData),
        .exImm(exImm),
        .exPcPlus4(exPcPlus4),
        .wbEn(wbValid),
        .wbRegIn(wbReg),
        .wbDataIn(wbData),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .memAluResult(memAluResult),
        .memStoreData(memStoreData),
        .memRd(memRd),
        .memRegWrite(memRegWrite),
        .memMemRead(memMemRead),
        .memMemWrite(memMemWrite),
        .memMemToReg(memMemToReg)
    );

    memStage #(
        .DataWords(DataWords)
    ) mem0 (
        .clk(clk),
        .arstN(arstN),
        .memAluResult(memAluResult),
        .memStoreData(memStoreData),
        .memRd(memRd),
        .memRegWrite(memRegWrite),
        .memMemRead(memMemRead),
        .memMemWrite(memMemWrite),
        .memMemToReg(memMemToReg),
        .wbEn(wbValid),
        .wbReg(wbReg),
        .wbData(wbData)
    );

endmodule

`default_nettype wire

// File: verif/mipsCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCoreTb import mipsPkg::*; ();

    localparam int clkPeriod    = 8;
    localparam int resetCycles  = 10;
    localparam int timeoutLimit = 2000;
    localparam int quietCycles  = 16;
    localparam int modelSteps   = 1000;
    localparam int progDepth    = 256;
    localparam word_t resetPc   = '0;
    localparam logic [15:0] lfsrSeed = 16'd82;

    logic     clk;
    logic     arstN;
    word_t    instrAddr;
    instr_t   instr;
    logic     wbValid;
    regAddr_t wbReg;
    word_t    wbData;

    instr_t      prog [progDepth];
    int          progLen;
    regAddr_t    expReg [$];
    word_t       expData [$];
    logic [15:0] lfsrState;

    mipsCore #(
        .ResetPc(resetPc),
        .DataWords(256)
    ) dut0 (
        .clk(clk),
        .arstN(arstN),
        .instrAddr(instrAddr),
        .instr(instr),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbData(wbData)
    );

    always #(clkPeriod/2) clk = ~clk;

    // Instruction memory returns a nop past the end of the program
    assign instr = (int'(instrAddr >> 2) < progLen) ? prog[instrAddr[9:2]] : '0;

    function automatic logic [15:0] lfsrNext(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic takeBits(input int n, output logic [15:0] value);
        value = '0;
        for (int k = 0; k < n; k++) begin
            value[k] = lfsrState[0];
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    function automatic instr_t encodeR(funct_t fn, int rd, int rs, int rt);
        instr_t w;
        w = '0;
        w.r.opcode = opRType;
        w.r.rs     = regAddr_t'(rs);
        w.r.rt     = regAddr_t'(rt);
        w.r.rd     = regAddr_t'(rd);
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic instr_t encodeI(opcode_t op, int rt, int rs, int imm);
        instr_t w;
        w = '0;
        w.i.opcode = op;
        w.i.rs     = regAddr_t'(rs);
        w.i.rt     = regAddr_t'(rt);
        w.i.imm    = imm[15:0];
        return w;
    endfunction

    function automatic word_t signExtend(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic addInstr(instr_t w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping");
    endtask

    task automatic compareReg(string testName, string what, regAddr_t exp, regAddr_t act);
        if (act !== exp) begin
            abortRun($sformatf("Fail %s: %s expected %0d actual %0d",
                               testName, what, exp, act));
        end
    endtask

    task automatic compareWord(string testName, string what, word_t exp, word_t act);
        if (act !== exp) begin
            abortRun($sformatf("Fail %s: %s expected 0x%08h actual 0x%08h",
                               testName, what, exp, act));
        end
    endtask

    // Reset held while the next program is built
    task automatic startTest();
        @(posedge clk);
        #1;
        arstN = 1'b0;
        progLen = 0;
        for (int k = 0; k < progDepth; k++) begin
            prog[k] = '0;
        end
    endtask

    // Instruction-set model stepping one instruction at a time in program order
    task automatic runModel();
        word_t    regs [32];
        word_t    dmem [256];
        word_t    pc;
        word_t    a;
        word_t    b;
        word_t    res;
        word_t    addr;
        instr_t   w;
        logic     wr;
        regAddr_t dst;
        int       steps;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        for (int k = 0; k < 256; k++) begin
            dmem[k] = '0;
        end
        expReg.delete();
        expData.delete();
        pc = resetPc;
        steps = 0;
        while (int'(pc >> 2) < progLen && steps < modelSteps) begin
            w    = prog[pc >> 2];
            a    = regs[w.r.rs];
            b    = regs[w.r.rt];
            addr = a + signExtend(w.i.imm);
            wr   = 1'b0;
            dst  = w.r.rd;
            res  = '0;
            pc   = pc + 4;
            steps++;
            case (w.r.opcode)
                opRType: begin
                    wr = 1'b1;
                    case (w.r.funct)
                        fnAdd:   res = a + b;
                        fnSub:   res = a - b;
                        fnAnd:   res = a & b;
                        fnOr:    res = a | b;
                        fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                opAddi: begin
                    wr  = 1'b1;
                    dst = w.i.rt;
                    res = addr;
                end
                opLw: begin
                    wr  = 1'b1;
                    dst = w.i.rt;
                    res = dmem[addr[9:2]];
                end
                opSw: dmem[addr[9:2]] = b;
                opBeq: begin
                    if (a == b) begin
                        pc = pc + (signExtend(w.i.imm) << 2);
                    end
                end
                default: ;
            endcase
            if (wr && dst != '0) begin
                regs[dst] = res;
                expReg.push_back(dst);
                expData.push_back(res);
            end
        end
    endtask

    // Release reset, then match every write-back against the model
    task automatic runAndCheck(string testName);
        int idx;
        int waited;
        int quiet;
        runModel();
        repeat (resetCycles) @(posedge clk);
        #1;
        compareWord(testName, "fetch address in reset", resetPc, instrAddr);
        arstN = 1'b1;
        idx = 0;
        waited = 0;
        while (idx < expReg.size()) begin
            @(negedge clk);
            waited++;
            if (wbValid === 1'b1) begin
                compareReg(testName, $sformatf("write %0d register", idx), expReg[idx], wbReg);
                compareWord(testName, $sformatf("write %0d data", idx), expData[idx], wbData);
                idx++;
            end
            if (waited > timeoutLimit) begin
                abortRun($sformatf("%s timed out after %0d of %0d register writes",
                                   testName, idx, expReg.size()));
            end
        end
        quiet = 0;
        waited = 0;
        while (quiet < quietCycles) begin
            @(negedge clk);
            waited++;
            if (wbValid !== 1'b0) begin
                abortRun($sformatf("%s wrote register %0d after the last expected write",
                                   testName, wbReg));
            end
            // Quiet cycles count only once fetch is past the program
            if (int'(instrAddr >> 2) < progLen) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            if (waited > timeoutLimit) begin
                abortRun($sformatf("%s never fetched past the end of the program", testName));
            end
        end
    endtask

    task automatic testAlu();
        startTest();
        addInstr(encodeI(opAddi, 1, 0, 5));
        addInstr(encodeI(opAddi, 2, 0, -3));
        addInstr(encodeR(fnAdd, 3, 1, 2));
        addInstr(encodeR(fnSub, 4, 1, 2));
        addInstr(encodeR(fnAnd, 5, 1, 2));
        addInstr(encodeR(fnOr, 6, 1, 2));
        addInstr(encodeR(fnSlt, 7, 2, 1));
        addInstr(encodeR(fnSlt, 8, 1, 2));
        addInstr(encodeI(opAddi, 9, 0, -32768));
        addInstr(encodeI(opAddi, 10, 9, 32767));
        runAndCheck("alu");
    endtask

    task automatic testForwarding();
        startTest();
        addInstr(encodeI(opAddi, 1, 0, 10));
        // Operands forwarded from the memory and write-back stages
        addInstr(encodeR(fnAdd, 2, 1, 1));
        addInstr(encodeR(fnAdd, 3, 2, 1));
        addInstr(encodeR(fnSub, 4, 3, 2));
        addInstr('0);
        addInstr(encodeR(fnAdd, 5, 4, 3));
        addInstr(encodeR(fnOr, 6, 5, 1));
        addInstr(encodeR(fnSub, 6, 6, 5));
        runAndCheck("forwarding");
    endtask

    task automatic testLoadStore();
        startTest();
        addInstr(encodeI(opAddi, 1, 0, 77));
        addInstr(encodeI(opAddi, 2, 0, 16));
        addInstr(encodeI(opSw, 1, 2, 0));
        addInstr(encodeI(opLw, 3, 2, 0));
        // Load-use needs one bubble
        addInstr(encodeR(fnAdd, 4, 3, 1));
        addInstr(encodeI(opSw, 4, 2, 4));
        addInstr(encodeI(opLw, 5, 2, 4));
        addInstr(encodeI(opLw, 6, 2, 0));
        addInstr(encodeR(fnSub, 7, 5, 6));
        runAndCheck("loadStore");
    endtask

    task automatic testBranch();
        startTest();
        addInstr(encodeI(opAddi, 1, 0, 3));
        addInstr(encodeI(opAddi, 2, 0, 3));
        addInstr(encodeI(opBeq, 2, 1, 2));
        addInstr(encodeI(opAddi, 3, 0, 111));
        addInstr(encodeI(opAddi, 4, 0, 222));
        addInstr(encodeI(opAddi, 5, 0, 333));
        addInstr(encodeI(opBeq, 0, 1, 1));
        addInstr(encodeI(opAddi, 6, 0, 44));
        addInstr(encodeI(opAddi, 7, 0, 55));
        runAndCheck("branch");
    endtask

    task automatic testRegZero();
        startTest();
        addInstr(encodeI(opAddi, 0, 0, 99));
        addInstr(encodeI(opAddi, 1, 0, 5));
        addInstr(encodeR(fnAdd, 0, 1, 1));
        addInstr(encodeR(fnAdd, 2, 0, 1));
        addInstr(encodeR(fnOr, 3, 0, 0));
        runAndCheck("regZero");
    endtask

    task automatic testRandom();
        logic [15:0] kind;
        logic [15:0] rd;
        logic [15:0] rs;
        logic [15:0] rt;
        logic [15:0] imm;
        startTest();
        for (int k = 0; k < 40; k++) begin
            takeBits(3, kind);
            takeBits(3, rd);
            takeBits(3, rs);
            takeBits(3, rt);
            takeBits(16, imm);
            case (kind)
                0: addInstr(encodeR(fnAdd, rd, rs, rt));
                1: addInstr(encodeR(fnSub, rd, rs, rt));
                2: addInstr(encodeR(fnAnd, rd, rs, rt));
                3: addInstr(encodeR(fnOr, rd, rs, rt));
                4: addInstr(encodeR(fnSlt, rd, rs, rt));
                default: addInstr(encodeI(opAddi, rd, rs, imm));
            endcase
        end
        runAndCheck("random");
    endtask

    initial begin
        clk = 1'b0;
        arstN = 1'b0;
        progLen = 0;
        lfsrState = lfsrSeed;
        testAlu();
        testForwarding();
        testLoadStore();
        testBranch();
        testRegZero();
        testRandom();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
common/mipsPkg.sv
hw/hazardUnit.sv
hw/fetch/fetchStage.sv
hw/decode/regFile.sv
hw/decode/decodeStage.sv
hw/execute/executeStage.sv
hw/memory/memStage.sv
hw/mipsCore.sv
verif/mipsCoreTb.sv

// File: Bender.yml
package:
  name: mipsCore

sources:
  - common/mipsPkg.sv
  - hw/hazardUnit.sv
  - hw/fetch/fetchStage.sv
  - hw/decode/regFile.sv
  - hw/decode/decodeStage.sv
  - hw/execute/executeStage.sv
  - hw/memory/memStage.sv
  - hw/mipsCore.sv
  - target: test
    files:
      - verif/mipsCoreTb.sv
